// File: hw/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

	typedef logic [15:0] lc3b_word; // Data values and byte addresses.
	typedef logic [2:0] lc3b_reg;

	// Opcode field, bits 15:12 of every instruction.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass // Forwards operand a, used for register jump targets.
	} alu_ops;

endpackage

`default_nettype wire

// File: hw/lc3b_ctrl_pkg.sv
`default_nettype none

package lc3b_ctrl_pkg;

	import lc3b_isa_pkg::*;

	// Second ALU operand. The offset is the word-scaled offset6 of LDR and STR.
	typedef enum logic [2:0] {
		alumux_off6 = 3'b000,
		alumux_imm5 = 3'b001,
		alumux_sr2  = 3'b100
	} alumux_sel_t;

	typedef enum logic [2:0] {
		pcmux_seq = 3'b000, // Next sequential word.
		pcmux_br  = 3'b001, // Conditional, PC relative.
		pcmux_reg = 3'b010, // Base register through the ALU.
		pcmux_rel = 3'b100  // Unconditional, PC relative.
	} pcmux_sel_t;

	typedef enum logic [2:0] {
		rfmux_alu  = 3'b000,
		rfmux_link = 3'b001,
		rfmux_lea  = 3'b010,
		rfmux_mem  = 3'b011
	} regfilemux_sel_t;

	typedef struct packed {
		lc3b_opcode opcode;
		pcmux_sel_t pcmux_sel;
		alumux_sel_t alumux_sel;
		alu_ops aluop;
		regfilemux_sel_t regfilemux_sel;
		logic [1:0] mdrmux_sel; // Load data format, 2'b10 takes the low byte.
		logic sr2mux_sel;
		logic destmux_sel;
		logic adjmux_sel;
		logic mem_read;
		logic mem_write;
		logic regfile_load;
		logic cc_load;
	} lc3b_control;

endpackage

`default_nettype wire

// File: hw/gen_control.sv
`timescale 1ns/1ns
`default_nettype none

module gen_control import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*; (
	input lc3b_opcode opcode,
	input logic [11:0] IRbits,
	output lc3b_control ctrl
);

	always_comb begin
		// Everything inactive unless the opcode below asks for it.
		ctrl.opcode = opcode;
		ctrl.pcmux_sel = pcmux_seq;
		ctrl.alumux_sel = alumux_off6;
		ctrl.aluop = alu_add;
		ctrl.regfilemux_sel = rfmux_alu;
		ctrl.mdrmux_sel = 2'b00;
		ctrl.sr2mux_sel = 1'b0;
		ctrl.destmux_sel = 1'b0;
		ctrl.adjmux_sel = 1'b0;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.regfile_load = 1'b0;
		ctrl.cc_load = 1'b0;

		case (opcode)
			op_add, op_and: begin
				if (IRbits[5]) begin
					ctrl.alumux_sel = alumux_imm5;
				end else begin
					ctrl.alumux_sel = alumux_sr2;
				end
				if (opcode == op_and) begin
					ctrl.aluop = alu_and;
				end
				ctrl.regfile_load = 1'b1;
				ctrl.cc_load = 1'b1;
			end
			op_not: begin
				ctrl.aluop = alu_not;
				ctrl.regfile_load = 1'b1;
				ctrl.cc_load = 1'b1;
			end
			op_br: begin
				ctrl.pcmux_sel = pcmux_br; // Offset9 is the adjust default.
			end
			op_jmp: begin
				ctrl.pcmux_sel = pcmux_reg;
				ctrl.aluop = alu_pass;
			end
			op_jsr: begin
				// Both forms link the return address into R7.
				ctrl.destmux_sel = 1'b1;
				ctrl.regfilemux_sel = rfmux_link;
				ctrl.regfile_load = 1'b1;
				if (IRbits[11]) begin
					ctrl.pcmux_sel = pcmux_rel; // JSR, offset11.
					ctrl.adjmux_sel = 1'b1;
				end else begin
					ctrl.pcmux_sel = pcmux_reg; // JSRR, base register.
					ctrl.aluop = alu_pass;
				end
			end
			op_lea: begin
				ctrl.regfilemux_sel = rfmux_lea;
				ctrl.regfile_load = 1'b1;
				ctrl.cc_load = 1'b1;
			end
			op_ldr: begin
				ctrl.alumux_sel = alumux_off6;
				ctrl.mem_read = 1'b1;
				ctrl.mdrmux_sel = 2'b01;
				ctrl.regfilemux_sel = rfmux_mem;
				ctrl.regfile_load = 1'b1;
				ctrl.cc_load = 1'b1;
			end
			op_str: begin
				ctrl.alumux_sel = alumux_off6;
				ctrl.sr2mux_sel = 1'b1; // Store source sits in bits 11:9.
				ctrl.mem_write = 1'b1;
			end
			// RTI, SHF, LDB, STB, LDI, STI and TRAP pass through as no-ops.
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import lc3b_isa_pkg::*; (
	input alu_ops aluop,
	input lc3b_word a,
	input lc3b_word b,
	output lc3b_word f
);

	always_comb begin
		case (aluop)
			alu_add: f = a + b; // Also forms LDR and STR addresses.
			alu_and: f = a & b;
			alu_not: f = ~a;
			default: f = a;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile import lc3b_isa_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic load,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	input lc3b_reg dest,
	input lc3b_word in,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

	lc3b_word data [8];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				data[i] <= '0;
			end
		end else if (load) begin
			data[dest] <= in;
		end
	end

	// Reads see the old value in the cycle of a write.
	assign reg_a = data[src_a];
	assign reg_b = data[src_b];

endmodule

`default_nettype wire

// File: hw/retire_port.sv
`timescale 1ns/1ns
`default_nettype none

module retire_port import lc3b_isa_pkg::*; #(
	parameter int NUM_CREDITS = 4
) (
	input logic clk,
	input logic arst_n,
	input logic fire,
	input lc3b_word pc,
	input logic reg_we,
	input lc3b_reg reg_idx,
	input lc3b_word data,
	input logic [2:0] cc,
	input logic ret_credit,
	output logic stall,
	output logic ret_valid,
	output lc3b_word ret_pc,
	output logic ret_reg_we,
	output lc3b_reg ret_reg,
	output lc3b_word ret_data,
	output logic [2:0] ret_cc
);

	logic [3:0] credits;

	// A record is charged when the instruction fires, one cycle before ret_valid.
	assign stall = (credits == 4'd0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= 4'(NUM_CREDITS);
			ret_valid <= 1'b0;
		end else begin
			credits <= credits - 4'(fire) + 4'(ret_credit);
			ret_valid <= fire;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			ret_pc <= pc;
			ret_reg_we <= reg_we;
			ret_reg <= reg_idx;
			ret_data <= data;
			ret_cc <= cc;
		end
	end

endmodule

`default_nettype wire

// File: hw/lc3b_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_datapath import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*; #(
	parameter lc3b_word RESET_PC = '0
) (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input lc3b_control ctrl,
	input lc3b_word alu_f,
	input lc3b_word reg_a,
	input lc3b_word reg_b,
	input lc3b_word imem_rdata,
	input lc3b_word dmem_rdata,
	output lc3b_opcode opcode,
	output logic [11:0] ir_bits,
	output alu_ops alu_op,
	output lc3b_word alu_a,
	output lc3b_word alu_b,
	output lc3b_reg src_a,
	output lc3b_reg src_b,
	output lc3b_reg dest,
	output logic rf_load,
	output lc3b_word rf_in,
	output lc3b_word imem_addr,
	output lc3b_word dmem_addr,
	output lc3b_word dmem_wdata,
	output logic dmem_we,
	output logic fire,
	output lc3b_word rec_pc,
	output logic rec_reg_we,
	output lc3b_reg rec_reg,
	output lc3b_word rec_data,
	output logic [2:0] rec_cc
);

	lc3b_word pc, ifid_pc, ifid_ir, pc_inc, pcrel, pc_target, load_data;
	logic ifid_valid, taken, redirect;
	logic [2:0] cc, cc_next;

	assign opcode = lc3b_opcode'(ifid_ir[15:12]);
	assign ir_bits = ifid_ir[11:0];
	assign fire = ifid_valid & ~stall;

	// PC relative targets are taken from the incremented PC.
	assign pc_inc = ifid_pc + 16'd2;
	assign pcrel = pc_inc + (ctrl.adjmux_sel ? {{4{ifid_ir[10]}}, ifid_ir[10:0], 1'b0}
		: {{6{ifid_ir[8]}}, ifid_ir[8:0], 1'b0});

	assign src_a = ifid_ir[8:6]; // SR1 and base register share this field.
	assign src_b = ctrl.sr2mux_sel ? ifid_ir[11:9] : ifid_ir[2:0];
	assign dest = ctrl.destmux_sel ? 3'd7 : ifid_ir[11:9];

	assign alu_op = ctrl.aluop;
	assign alu_a = reg_a;
	always_comb begin
		case (ctrl.alumux_sel)
			alumux_sr2: alu_b = reg_b;
			alumux_imm5: alu_b = {{11{ifid_ir[4]}}, ifid_ir[4:0]};
			default: alu_b = {{9{ifid_ir[5]}}, ifid_ir[5:0], 1'b0};
		endcase
	end

	assign load_data = (ctrl.mdrmux_sel == 2'b10) ? {8'h00, dmem_rdata[7:0]} : dmem_rdata;

	always_comb begin
		case (ctrl.regfilemux_sel)
			rfmux_link: rf_in = pc_inc;
			rfmux_lea: rf_in = pcrel;
			rfmux_mem: rf_in = load_data;
			default: rf_in = alu_f;
		endcase
	end

	always_comb begin
		if (rf_in[15]) cc_next = 3'b100;
		else if (rf_in == '0) cc_next = 3'b010;
		else cc_next = 3'b001;
	end

	always_comb begin
		taken = 1'b0;
		pc_target = pcrel;
		case (ctrl.pcmux_sel)
			pcmux_br: taken = |(ifid_ir[11:9] & cc);
			pcmux_rel: taken = 1'b1;
			pcmux_reg: begin
				taken = 1'b1;
				pc_target = alu_f; // Base register passed through the ALU.
			end
			default: taken = 1'b0;
		endcase
	end

	assign redirect = fire & taken;
	assign rf_load = fire & ctrl.regfile_load;

	// Both memory ports take word addresses.
	assign imem_addr = {1'b0, pc[15:1]};
	assign dmem_addr = (ctrl.mem_read | ctrl.mem_write) ? {1'b0, alu_f[15:1]} : '0;
	assign dmem_wdata = reg_b;
	assign dmem_we = fire & ctrl.mem_write;

	assign rec_pc = ifid_pc;
	assign rec_reg_we = ctrl.regfile_load;
	assign rec_reg = dest;
	assign rec_data = rf_in;
	assign rec_cc = ctrl.cc_load ? cc_next : cc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
			ifid_valid <= 1'b0;
			cc <= 3'b010;
		end else if (!stall) begin
			pc <= redirect ? pc_target : pc + 16'd2;
			ifid_valid <= ~redirect; // The word fetched this cycle is off the taken path.
			if (fire && ctrl.cc_load) begin
				cc <= cc_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifid_ir <= imem_rdata;
			ifid_pc <= pc;
		end
	end

endmodule

`default_nettype wire

// File: hw/lc3b_core.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_core import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*; #(
	parameter int NUM_CREDITS = 4,
	parameter lc3b_word RESET_PC = '0
) (
	input logic clk,
	input logic arst_n,
	output lc3b_word imem_addr,
	input lc3b_word imem_rdata,
	output lc3b_word dmem_addr,
	output lc3b_word dmem_wdata,
	output logic dmem_we,
	input lc3b_word dmem_rdata,
	output logic ret_valid,
	output lc3b_word ret_pc,
	output logic ret_reg_we,
	output lc3b_reg ret_reg,
	output lc3b_word ret_data,
	output logic [2:0] ret_cc,
	input logic ret_credit
);

	lc3b_control ctrl;
	lc3b_opcode opcode;
	logic [11:0] ir_bits;
	alu_ops alu_op;
	lc3b_word alu_a, alu_b, alu_f, reg_a, reg_b, rf_in, rec_pc, rec_data;
	lc3b_reg src_a, src_b, dest, rec_reg;
	logic stall, fire, rf_load, rec_reg_we;
	logic [2:0] rec_cc;

	gen_control u_control (.opcode(opcode), .IRbits(ir_bits), .ctrl(ctrl));

	lc3b_datapath #(.RESET_PC(RESET_PC)) u_datapath (
		.clk(clk), .arst_n(arst_n), .stall(stall), .ctrl(ctrl), .alu_f(alu_f),
		.reg_a(reg_a), .reg_b(reg_b), .imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata),
		.opcode(opcode), .ir_bits(ir_bits), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
		.src_a(src_a), .src_b(src_b), .dest(dest), .rf_load(rf_load), .rf_in(rf_in),
		.imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we), .fire(fire), .rec_pc(rec_pc), .rec_reg_we(rec_reg_we),
		.rec_reg(rec_reg), .rec_data(rec_data), .rec_cc(rec_cc)
	);

	alu u_alu (.aluop(alu_op), .a(alu_a), .b(alu_b), .f(alu_f));

	regfile u_regfile (
		.clk(clk), .arst_n(arst_n), .load(rf_load), .src_a(src_a), .src_b(src_b),
		.dest(dest), .in(rf_in), .reg_a(reg_a), .reg_b(reg_b)
	);

	retire_port #(.NUM_CREDITS(NUM_CREDITS)) u_retire (
		.clk(clk), .arst_n(arst_n), .fire(fire), .pc(rec_pc), .reg_we(rec_reg_we),
		.reg_idx(rec_reg), .data(rec_data), .cc(rec_cc), .ret_credit(ret_credit),
		.stall(stall), .ret_valid(ret_valid), .ret_pc(ret_pc), .ret_reg_we(ret_reg_we),
		.ret_reg(ret_reg), .ret_data(ret_data), .ret_cc(ret_cc)
	);

endmodule

`default_nettype wire

// File: testbench/lc3b_ref_model.svh
`ifndef LC3B_REF_MODEL_SVH
`define LC3B_REF_MODEL_SVH

// Instruction-set model of the core. Each call to step_model executes one instruction
// from imem and queues the retire record and any store that the core should produce.

typedef struct packed {
	logic [15:0] pc;
	logic reg_we;
	logic [2:0] dest;
	logic [15:0] data;
	logic [2:0] cc;
} ret_rec_t;

typedef struct packed {
	logic [15:0] addr; // Word address as it appears on dmem_addr.
	logic [15:0] data;
} store_rec_t;

logic [15:0] m_regs [8];
logic [15:0] m_dmem [256];
logic [15:0] m_pc;
logic [2:0] m_cc;
ret_rec_t exp_recs [$];
store_rec_t exp_stores [$];

function automatic logic [2:0] cc_of(logic [15:0] value);
	if (value[15]) begin
		return 3'b100;
	end
	if (value == 16'h0000) begin
		return 3'b010;
	end
	return 3'b001;
endfunction

task automatic reset_model();
	for (int i = 0; i < 8; i++) begin
		m_regs[i] = 16'h0000;
	end
	for (int i = 0; i < 256; i++) begin
		m_dmem[i] = dmem[i];
	end
	m_pc = RESET_PC;
	m_cc = 3'b010; // Zero flag after reset.
	exp_recs.delete();
	exp_stores.delete();
endtask

task automatic step_model();
	logic [15:0] ir;
	logic [15:0] seq_pc;
	logic [15:0] next_pc;
	logic [15:0] sr1;
	logic [15:0] operand;
	logic [15:0] addr;
	logic [15:0] off9;
	logic [15:0] off11;
	ret_rec_t rec;
	store_rec_t st;
	ir = imem[m_pc[8:1]];
	seq_pc = m_pc + 16'd2;
	next_pc = seq_pc;
	sr1 = m_regs[ir[8:6]];
	operand = ir[5] ? {{11{ir[4]}}, ir[4:0]} : m_regs[ir[2:0]];
	addr = sr1 + {{9{ir[5]}}, ir[5:0], 1'b0}; // Offsets count words.
	off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
	off11 = {{4{ir[10]}}, ir[10:0], 1'b0};
	rec.pc = m_pc;
	rec.reg_we = 1'b0;
	rec.dest = ir[11:9];
	rec.data = 16'h0000;
	rec.cc = m_cc;
	case (ir[15:12])
		4'h1: begin
			rec.reg_we = 1'b1;
			rec.data = sr1 + operand;
		end
		4'h5: begin
			rec.reg_we = 1'b1;
			rec.data = sr1 & operand;
		end
		4'h9: begin
			rec.reg_we = 1'b1;
			rec.data = ~sr1;
		end
		4'he: begin
			rec.reg_we = 1'b1;
			rec.data = seq_pc + off9;
		end
		4'h6: begin
			rec.reg_we = 1'b1;
			rec.data = m_dmem[addr[8:1]];
		end
		4'h7: begin
			st.addr = {1'b0, addr[15:1]};
			st.data = m_regs[ir[11:9]];
			exp_stores.push_back(st);
			m_dmem[addr[8:1]] = st.data;
		end
		4'h0: begin
			if (|(ir[11:9] & m_cc)) begin
				next_pc = seq_pc + off9;
			end
		end
		4'hc: next_pc = sr1;
		4'h4: begin
			// JSR and JSRR link the return address into R7.
			rec.reg_we = 1'b1;
			rec.dest = 3'd7;
			rec.data = seq_pc;
			next_pc = ir[11] ? seq_pc + off11 : sr1;
		end
		default: ; // Opcodes outside the subset change nothing.
	endcase
	if (ir[15:12] inside {4'h1, 4'h5, 4'h9, 4'he, 4'h6}) begin
		m_cc = cc_of(rec.data);
		rec.cc = m_cc;
	end
	if (rec.reg_we) begin
		m_regs[rec.dest] = rec.data;
	end
	exp_recs.push_back(rec);
	m_pc = next_pc;
endtask

`endif

// File: testbench/tb_lc3b.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lc3b;

	localparam int NUM_CREDITS = 4;
	localparam logic [15:0] RESET_PC = 16'h0020;
	localparam int CLK_PERIOD = 4;
	localparam int SEED = 15197;
	localparam int RUN_LEN = 200;
	localparam int CREDIT_RUN_LEN = 150;
	localparam int TOTAL_INSTR = 4 * RUN_LEN + CREDIT_RUN_LEN;
	localparam int MAX_CREDIT_DELAY = 24;
	localparam int WATCHDOG_NS = 10 * TOTAL_INSTR * MAX_CREDIT_DELAY * CLK_PERIOD;

	logic clk;
	logic arst_n;
	logic [15:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
	logic [15:0] ret_pc, ret_data;
	logic dmem_we, ret_valid, ret_reg_we, ret_credit;
	logic [2:0] ret_reg, ret_cc;

	logic [15:0] imem [256];
	logic [15:0] dmem [256];

	int errors;
	int tests_passed;
	int tests_failed;
	int rec_count;
	int stores_seen;
	int tb_credits; // Credits the core holds as seen by the receiver.
	int credits_given;
	int credit_hold;
	int credit_ceiling;
	int unsigned seed_val;

	`include "lc3b_ref_model.svh"

	lc3b_core #(.NUM_CREDITS(NUM_CREDITS), .RESET_PC(RESET_PC)) dut (
		.clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata), .ret_valid(ret_valid), .ret_pc(ret_pc),
		.ret_reg_we(ret_reg_we), .ret_reg(ret_reg), .ret_data(ret_data), .ret_cc(ret_cc),
		.ret_credit(ret_credit)
	);

	assign imem_rdata = imem[imem_addr[7:0]];
	assign dmem_rdata = dmem[dmem_addr[7:0]];

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[7:0]] <= dmem_wdata;
		end
	end

	task automatic report_mismatch(string signal, logic [15:0] expected, logic [15:0] actual);
		$display("ERR %s expected %h actual %h at %0t", signal, expected, actual, $time);
		errors++;
	endtask

	task automatic check_record();
		ret_rec_t exp;
		assert (exp_recs.size() > 0) else begin
			$display("Record for pc %h arrived after the model ran out of instructions.", ret_pc);
			errors++;
		end
		if (exp_recs.size() > 0) begin
			exp = exp_recs.pop_front();
			assert (ret_pc == exp.pc) else report_mismatch("ret_pc", exp.pc, ret_pc);
			assert (ret_reg_we == exp.reg_we)
				else report_mismatch("ret_reg_we", exp.reg_we, ret_reg_we);
			assert (ret_cc == exp.cc) else report_mismatch("ret_cc", exp.cc, ret_cc);
			if (exp.reg_we) begin
				assert (ret_reg == exp.dest) else report_mismatch("ret_reg", exp.dest, ret_reg);
				assert (ret_data == exp.data) else report_mismatch("ret_data", exp.data, ret_data);
			end
		end
	endtask

	task automatic check_store();
		store_rec_t exp;
		stores_seen++;
		assert (exp_stores.size() > 0) else begin
			$display("Store to word %h was not expected by the model.", dmem_addr);
			errors++;
		end
		if (exp_stores.size() > 0) begin
			exp = exp_stores.pop_front();
			assert (dmem_addr == exp.addr) else report_mismatch("dmem_addr", exp.addr, dmem_addr);
			assert (dmem_wdata == exp.data)
				else report_mismatch("dmem_wdata", exp.data, dmem_wdata);
		end
	endtask

	// Outputs are sampled at the rising edge and inputs change on the falling edge.
	always @(posedge clk) begin
		if (!arst_n) begin
			rec_count = 0;
			stores_seen = 0;
			tb_credits = NUM_CREDITS;
		end else begin
			if (ret_valid) begin
				assert (tb_credits > 0) else begin
					$display("Record for pc %h was sent while the core held no credit.", ret_pc);
					errors++;
				end
				check_record();
				rec_count++;
			end
			if (dmem_we) begin
				check_store();
			end
			tb_credits = tb_credits - int'(ret_valid) + int'(ret_credit);
		end
	end

	// Returns one credit per received record after a random hold.
	always @(negedge clk) begin
		if (!arst_n) begin
			ret_credit = 1'b0;
			credits_given = 0;
			credit_hold = 0;
		end else begin
			ret_credit = 1'b0;
			if (credit_hold > 0) begin
				credit_hold--;
			end else if (rec_count > credits_given) begin
				ret_credit = 1'b1;
				credits_given++;
				credit_hold = $urandom_range(credit_ceiling, 0);
			end
		end
	end

	function automatic logic [15:0] draw_instr(int mix);
		logic [63:0] ops;
		int count;
		int pick;
		logic [3:0] op;
		case (mix)
			0: begin
				ops = 64'h159e;
				count = 4;
			end
			1: begin
				ops = 64'h1590c401; // Branches and jumps between register updates.
				count = 8;
			end
			2: begin
				ops = 64'h15676e1;
				count = 7;
			end
			3: begin
				ops = 64'h1567238abdf;
				count = 11;
			end
			default: begin
				ops = 64'h0145679ce;
				count = 9;
			end
		endcase
		pick = $urandom_range(count - 1, 0);
		op = ops[4 * pick +: 4];
		if (mix == 4 && $urandom_range(7, 0) == 0) begin
			pick = $urandom_range(6, 0);
			op = 4'(28'h238abdf >> (4 * pick));
		end
		return {op, 12'($urandom)};
	endfunction

	task automatic load_program(int mix);
		for (int i = 0; i < 256; i++) begin
			imem[i] = draw_instr(mix);
			dmem[i] = 16'(i * 16'h2f1b) ^ {8'(mix), 8'h3c};
		end
	endtask

	task automatic run_test(string name, int mix, int len, int ceiling);
		int errors_before;
		int stores_expected;
		@(negedge clk);
		arst_n = 1'b0;
		errors_before = errors;
		credit_ceiling = ceiling;
		load_program(mix);
		reset_model();
		for (int i = 0; i < len; i++) begin
			step_model();
		end
		stores_expected = exp_stores.size();
		for (int i = 0; i < 8; i++) begin
			step_model(); // Instructions that may fire before the next reset.
		end
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		#1;
		assert (ret_valid == 1'b0) else report_mismatch("ret_valid", 16'h0000, ret_valid);
		assert (dmem_we == 1'b0) else report_mismatch("dmem_we", 16'h0000, dmem_we);
		assert (imem_addr == {1'b0, RESET_PC[15:1]})
			else report_mismatch("imem_addr", {1'b0, RESET_PC[15:1]}, imem_addr);
		while (rec_count < len) begin
			@(negedge clk);
		end
		assert (stores_seen >= stores_expected) else begin
			$display("Only %0d of %0d expected stores reached the data port.",
				stores_seen, stores_expected);
			errors++;
		end
		if (errors == errors_before) begin
			tests_passed++;
			$display("Test %s: %0d records checked, ok", name, rec_count);
		end else begin
			tests_failed++;
			$display("Test %s: %0d records checked, %0d errors", name, rec_count,
				errors - errors_before);
		end
	endtask

	initial begin
		seed_val = $urandom(SEED);
		arst_n = 1'b0;
		ret_credit = 1'b0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		credit_ceiling = 1;
		run_test("arith_logic", 0, RUN_LEN, 1);
		run_test("control_flow", 1, RUN_LEN, 1);
		run_test("memory", 2, RUN_LEN, 2);
		run_test("unsupported", 3, RUN_LEN, 1);
		run_test("credit_flow", 4, CREDIT_RUN_LEN, MAX_CREDIT_DELAY);
		$display("Tests passed %0d, failed %0d, check errors %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Bounds the run by the slowest possible credit return on every instruction.
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the core stopped retiring.", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+testbench
hw/lc3b_isa_pkg.sv
hw/lc3b_ctrl_pkg.sv
hw/gen_control.sv
hw/alu.sv
hw/regfile.sv
hw/retire_port.sv
hw/lc3b_datapath.sv
hw/lc3b_core.sv
testbench/tb_lc3b.sv

// File: Bender.yml
package:
  name: lc3b_core

sources:
  - files:
      - hw/lc3b_isa_pkg.sv
      - hw/lc3b_ctrl_pkg.sv
      - hw/gen_control.sv
      - hw/alu.sv
      - hw/regfile.sv
      - hw/retire_port.sv
      - hw/lc3b_datapath.sv
      - hw/lc3b_core.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_lc3b.sv
